// ==== all.f ====
logic/tdma_pkg.sv
logic/gps_time_base.sv
logic/slot_scheduler.sv
logic/ping_engine.sv
logic/tdma_control.sv
testbench/tdma_control_tb.sv

// ==== testbench/tdma_control_tb.sv ====
`default_nettype none

module tdma_control_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                            clk;
    logic                            reset_n;
    logic                            timepulse_1;
    logic                            timepulse_2;
    logic [31:0]                     utc_sec;
    logic                            tdma_function_enable;
    logic [tdma_pkg::SLOT_W-1:0]     bch_user_pointer;
    logic                            start_ping;
    logic                            recv_ping;
    logic                            recv_ack_ping;
    tdma_pkg::ping_fields_t          recv_fields;
    logic                            open_loop;
    logic [tdma_pkg::ADDR_W-1:0]     skb_addr;
    logic                            burst_start;
    tdma_pkg::burst_req_t            burst_req;
    logic                            burst_ack;
    logic                            burst_done;
    logic                            ping_sent;
    tdma_pkg::ping_result_t          result;
    tdma_pkg::gps_time_t             gps_time;
    logic [tdma_pkg::TICK_W-1:0]     slot_tick_count;
    logic                            tdma_tx_enable;

    integer seed = 32'hf0eef4db;

    // reference counts kept by the testbench
    logic [31:0] m_utc;
    logic [31:0] m_p1;
    logic [31:0] m_p2;
    logic [31:0] m_seq;
    int          m_tick;
    int          m_slot;

    tdma_control DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reference functions
    ////////////////////////////////////////////////////////////
    function automatic tdma_pkg::gps_time_t exp_gps();
        tdma_pkg::gps_time_t g;
        g.utc_sec      = m_utc;
        g.pulse1_count = m_p1;
        g.pulse2_count = m_p2;
        return g;
    endfunction

    function automatic logic exp_txen();
        if (!tdma_function_enable)
            return 1'b1;
        return (bch_user_pointer != 0) && (bch_user_pointer == m_slot);
    endfunction

    function automatic tdma_pkg::burst_req_t exp_burst(input logic [31:0] flag,
                                                       input tdma_pkg::ping_fields_t f);
        tdma_pkg::burst_req_t b;
        b.addr   = skb_addr + 32'h20;
        b.length = 14'd16;
        b.data   = {f.counter2, f.sec, f.seq, flag};
        return b;
    endfunction

    function automatic tdma_pkg::ping_result_t exp_result(input tdma_pkg::ping_fields_t f);
        tdma_pkg::ping_result_t r;
        r.seq = f.seq;
        if (f.sec == m_utc)
            r.delta_t = m_p2 - f.counter2;
        else
            r.delta_t = m_p2 + 32'hF423F - f.counter2;
        return r;
    endfunction

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_gps(input string name, input tdma_pkg::gps_time_t exp,
                             input tdma_pkg::gps_time_t act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_burst(input string name, input tdma_pkg::burst_req_t exp,
                               input tdma_pkg::burst_req_t act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_result(input string name, input tdma_pkg::ping_result_t exp,
                                input tdma_pkg::ping_result_t act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_tick(input string name, input logic [tdma_pkg::TICK_W-1:0] exp,
                              input logic [tdma_pkg::TICK_W-1:0] act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////
    // one pulse edge with model update and a check 5 cycles after the rise
    task automatic pulse_edge(input bit second);
        int gap;
        if (second) begin
            utc_sec     = $random(seed);
            timepulse_1 = 1'b1;
        end else begin
            timepulse_2 = 1'b1;
        end
        @(negedge clk);
        timepulse_1 = 1'b0;
        timepulse_2 = 1'b0;
        if (second) begin
            m_p1   = m_p1 + 1;
            m_utc  = utc_sec;
            m_p2   = 0;
            m_tick = 0;
            m_slot = 0;
        end else begin
            m_p2 = m_p2 + 1;
            if (m_tick == tdma_pkg::SLOT_TICKS - 1) begin
                m_tick = 0;
                m_slot = (m_slot == tdma_pkg::FRAME_SLOTS - 1) ? 0 : m_slot + 1;
            end else begin
                m_tick = m_tick + 1;
            end
        end
        repeat (4) @(negedge clk);
        check_gps("time base", exp_gps(), gps_time);
        check_tick("slot tick count", m_tick, slot_tick_count);
        check_bit("tx enable", exp_txen(), tdma_tx_enable);
        gap = 3 + rand_below(4);
        repeat (gap) @(negedge clk);
    endtask

    task automatic run_ticks(input int n, input int sec_at);
        for (int i = 0; i < n; i++)
            pulse_edge(i == sec_at);
    endtask

    // host side of one burst write
    task automatic serve_burst(output tdma_pkg::burst_req_t req);
        int n;
        n = 0;
        while (!burst_start && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!burst_start)
            abort_run("timeout: burst_start never rose");
        req = burst_req;
        repeat (rand_below(6)) @(negedge clk);
        check_burst("burst_req held until ack", req, burst_req);
        burst_ack = 1'b1;
        @(negedge clk);
        burst_ack = 1'b0;
        check_bit("burst_start drops after ack", 1'b0, burst_start);
        repeat (rand_below(6)) @(negedge clk);
        burst_done = 1'b1;
        @(negedge clk);
        burst_done = 1'b0;
        n = 0;
        while (!ping_sent && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (!ping_sent)
            abort_run("timeout: ping_sent did not follow burst_done");
        @(negedge clk);
        check_bit("ping_sent one cycle wide", 1'b0, ping_sent);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        tdma_pkg::ping_fields_t f;
        tdma_pkg::burst_req_t   req;
        tdma_pkg::ping_result_t old;
        int                     n;
        reset_n              = 1'b0;
        timepulse_1          = 1'b0;
        timepulse_2          = 1'b0;
        utc_sec              = '0;
        tdma_function_enable = 1'b0;
        bch_user_pointer     = '0;
        start_ping           = 1'b0;
        recv_ping            = 1'b0;
        recv_ack_ping        = 1'b0;
        recv_fields          = '0;
        open_loop            = 1'b0;
        skb_addr             = $random(seed);
        burst_ack            = 1'b0;
        burst_done           = 1'b0;
        {m_utc, m_p1, m_p2, m_seq} = '0;
        m_tick = 0;
        m_slot = 0;
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_gps("reset time", '0, gps_time);
        check_result("reset result", '0, result);
        check_bit("reset tx enable", 1'b1, tdma_tx_enable);
        check_bit("reset burst_start", 1'b0, burst_start);
        check_bit("reset ping_sent", 1'b0, ping_sent);

        // random mix of both pulses for the time base
        for (int i = 0; i < 40; i++)
            pulse_edge(rand_below(6) == 0);

        // slot counting and tx window for each bch pointer and with tdma off
        for (int cfg = 0; cfg < 4; cfg++) begin
            tdma_function_enable = (cfg < 3);
            bch_user_pointer     = (cfg < 3) ? cfg : 1;
            if (cfg == 0)
                run_ticks(4600, 1500);
            else
                run_ticks(tdma_pkg::FRAME_SLOTS * tdma_pkg::SLOT_TICKS + 50, -1);
        end

        // ping send waits for the own slot
        tdma_function_enable = 1'b1;
        bch_user_pointer     = 1;
        pulse_edge(1);
        start_ping = 1'b1;
        @(negedge clk);
        start_ping = 1'b0;
        while (m_slot != 1) begin
            check_bit("no burst before tx window", 1'b0, burst_start);
            pulse_edge(0);
        end
        serve_burst(req);
        f = '{32'd1, m_utc, m_p2};
        m_seq = 32'd1;
        check_burst("ping send", exp_burst(32'd1, f), req);

        // ping reply echoes the fields
        f = '{$random(seed), $random(seed), $random(seed)};
        recv_fields = f;
        recv_ping   = 1'b1;
        @(negedge clk);
        recv_ping = 1'b0;
        serve_burst(req);
        check_burst("ping reply", exp_burst(32'd2, f), req);
        m_seq = f.seq;

        // ack-ping from another and the same second with open loop low and high
        for (int k = 0; k < 4; k++) begin
            open_loop = k[1];
            f.seq      = $random(seed);
            f.sec      = k[0] ? m_utc : m_utc + 1 + rand_below(100);
            f.counter2 = $random(seed);
            old = result;
            recv_fields   = f;
            recv_ack_ping = 1'b1;
            @(negedge clk);
            recv_ack_ping = 1'b0;
            n = 0;
            while (result === old && n < 10) begin
                @(negedge clk);
                n++;
            end
            check_result("ack-ping measurement", exp_result(f), result);
            if (open_loop) begin
                m_seq = m_seq + 1;
                serve_burst(req);
                check_burst("open loop ping", exp_burst(32'd1, '{m_seq, m_utc, m_p2}), req);
            end
            repeat (3) @(negedge clk);
        end

        // a new run inside the open tx window drops the last measurement
        start_ping = 1'b1;
        @(negedge clk);
        start_ping = 1'b0;
        serve_burst(req);
        m_seq = 32'd1;
        check_burst("second ping send", exp_burst(32'd1, '{m_seq, m_utc, m_p2}), req);
        check_result("start clears result", '0, result);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/tdma_control.sv ====
`default_nettype none

module tdma_control (
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire                              timepulse_1,
    input  wire                              timepulse_2,
    input  wire [31:0]                       utc_sec,
    input  wire                              tdma_function_enable,
    input  wire [tdma_pkg::SLOT_W-1:0]       bch_user_pointer,
    input  wire                              start_ping,
    input  wire                              recv_ping,
    input  wire                              recv_ack_ping,
    input  wire tdma_pkg::ping_fields_t      recv_fields,
    input  wire                              open_loop,
    input  wire [tdma_pkg::ADDR_W-1:0]       skb_addr,
    output wire                              burst_start,
    output wire tdma_pkg::burst_req_t        burst_req,
    input  wire                              burst_ack,
    input  wire                              burst_done,
    output wire                              ping_sent,
    output wire tdma_pkg::ping_result_t      result,
    output wire tdma_pkg::gps_time_t         gps_time,
    output wire [tdma_pkg::TICK_W-1:0]       slot_tick_count,
    output wire                              tdma_tx_enable
);

    wire sec_tick;
    wire us_tick;

    ////////////////////////////////////////////////////////////
    // time base, slots, ping
    ////////////////////////////////////////////////////////////
    gps_time_base u_time_base (
        .clk         (clk),
        .reset_n     (reset_n),
        .timepulse_1 (timepulse_1),
        .timepulse_2 (timepulse_2),
        .utc_sec     (utc_sec),
        .gps_time    (gps_time),
        .sec_tick    (sec_tick),
        .us_tick     (us_tick)
    );

    slot_scheduler u_slot_scheduler (
        .clk                  (clk),
        .reset_n              (reset_n),
        .sec_tick             (sec_tick),
        .us_tick              (us_tick),
        .tdma_function_enable (tdma_function_enable),
        .bch_user_pointer     (bch_user_pointer),
        .slot_tick_count      (slot_tick_count),
        .tdma_tx_enable       (tdma_tx_enable)
    );

    ping_engine u_ping_engine (
        .clk            (clk),
        .reset_n        (reset_n),
        .gps_time       (gps_time),
        .tdma_tx_enable (tdma_tx_enable),
        .start_ping     (start_ping),
        .recv_ping      (recv_ping),
        .recv_ack_ping  (recv_ack_ping),
        .recv_fields    (recv_fields),
        .open_loop      (open_loop),
        .skb_addr       (skb_addr),
        .burst_start    (burst_start),
        .burst_req      (burst_req),
        .burst_ack      (burst_ack),
        .burst_done     (burst_done),
        .ping_sent      (ping_sent),
        .result         (result)
    );

endmodule

`default_nettype wire

// ==== logic/ping_engine.sv ====
`default_nettype none

module ping_engine (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire tdma_pkg::gps_time_t       gps_time,
    input  wire                            tdma_tx_enable,
    input  wire                            start_ping,
    input  wire                            recv_ping,
    input  wire                            recv_ack_ping,
    input  wire tdma_pkg::ping_fields_t    recv_fields,
    input  wire                            open_loop,
    input  wire [tdma_pkg::ADDR_W-1:0]     skb_addr,
    output logic                           burst_start,
    output tdma_pkg::burst_req_t           burst_req,
    input  wire                            burst_ack,
    input  wire                            burst_done,
    output logic                           ping_sent,
    output tdma_pkg::ping_result_t         result
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_TXEN,
        S_SEND,
        S_WAIT_ACK,
        S_WAIT_DONE,
        S_SENT
    } state_t;

    state_t                          state;
    logic [tdma_pkg::DATA_W-1:0]     pkt_flag;
    tdma_pkg::ping_fields_t          pkt;
    logic [tdma_pkg::DATA_W-1:0]     delta_t;

    ////////////////////////////////////////////////////////////
    // round trip delta
    ////////////////////////////////////////////////////////////
    // a second boundary inside the measurement adds a full count
    always_comb begin
        if (recv_fields.sec == gps_time.utc_sec) begin
            delta_t = gps_time.pulse2_count - recv_fields.counter2;
        end else begin
            delta_t = gps_time.pulse2_count + tdma_pkg::MAX_COUNTER2
                      - recv_fields.counter2;
        end
    end

    ////////////////////////////////////////////////////////////
    // ping fsm
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= S_IDLE;
            pkt_flag    <= '0;
            pkt         <= '0;
            result      <= '0;
            burst_start <= 1'b0;
            ping_sent   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_ping) begin
                        state <= S_WAIT_TXEN;
                    end else if (recv_ping) begin
                        // echo the received fields back
                        pkt_flag <= tdma_pkg::FLAG_ACK_PING;
                        pkt      <= recv_fields;
                        state    <= S_SEND;
                    end else if (recv_ack_ping) begin
                        result.seq     <= recv_fields.seq;
                        result.delta_t <= delta_t;
                        if (open_loop) begin
                            pkt_flag     <= tdma_pkg::FLAG_PING;
                            pkt.seq      <= pkt.seq + 32'd1;
                            pkt.sec      <= gps_time.utc_sec;
                            pkt.counter2 <= gps_time.pulse2_count;
                            state        <= S_SEND;
                        end
                    end
                end
                S_WAIT_TXEN: begin
                    // first ping of a run goes out in the own slot
                    if (tdma_tx_enable) begin
                        result       <= '0;
                        pkt_flag     <= tdma_pkg::FLAG_PING;
                        pkt.seq      <= 32'd1;
                        pkt.sec      <= gps_time.utc_sec;
                        pkt.counter2 <= gps_time.pulse2_count;
                        state        <= S_SEND;
                    end
                end
                S_SEND: begin
                    burst_start <= 1'b1;
                    state       <= S_WAIT_ACK;
                end
                S_WAIT_ACK: begin
                    if (burst_ack) begin
                        burst_start <= 1'b0;
                        state       <= S_WAIT_DONE;
                    end
                end
                S_WAIT_DONE: begin
                    if (burst_done) begin
                        ping_sent <= 1'b1;
                        state     <= S_SENT;
                    end
                end
                S_SENT: begin
                    ping_sent <= 1'b0;
                    state     <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // burst request, loaded as burst_start goes up
    always_ff @(posedge clk) begin
        if (state == S_SEND) begin
            burst_req.addr   <= skb_addr + tdma_pkg::PAYLOAD_OFFSET;
            burst_req.length <= tdma_pkg::PING_BYTES;
            burst_req.data   <= {pkt.counter2, pkt.sec, pkt.seq, pkt_flag};
        end
    end

    a_req_stable: assert property (
        @(posedge clk) disable iff (!reset_n)
        (burst_start && !burst_ack) |=> $stable(burst_req)
    ) else $error("burst request changed before ack");

endmodule

`default_nettype wire

// ==== logic/slot_scheduler.sv ====
`default_nettype none

module slot_scheduler (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            sec_tick,
    input  wire                            us_tick,
    input  wire                            tdma_function_enable,
    input  wire [tdma_pkg::SLOT_W-1:0]     bch_user_pointer,
    output logic [tdma_pkg::TICK_W-1:0]    slot_tick_count,
    output logic                           tdma_tx_enable
);

    logic [tdma_pkg::SLOT_W-1:0] slot_ptr;
    logic [tdma_pkg::SLOT_W-1:0] bch_ptr;
    logic                        bch_valid;

    ////////////////////////////////////////////////////////////
    // slot and frame counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            slot_tick_count <= '0;
            slot_ptr        <= '0;
        end else if (sec_tick) begin
            // second boundary realigns the frame
            slot_tick_count <= '0;
            slot_ptr        <= '0;
        end else if (us_tick) begin
            if (slot_tick_count == tdma_pkg::TICK_LAST) begin
                slot_tick_count <= '0;
                if (slot_ptr == tdma_pkg::SLOT_LAST) begin
                    slot_ptr <= '0;
                end else begin
                    slot_ptr <= slot_ptr + 1'b1;
                end
            end else begin
                slot_tick_count <= slot_tick_count + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // own bch slot and transmit window
    ////////////////////////////////////////////////////////////
    // a zero pointer means no bch slot assigned
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bch_ptr   <= '0;
            bch_valid <= 1'b0;
        end else begin
            bch_ptr   <= bch_user_pointer;
            bch_valid <= (bch_user_pointer != '0);
        end
    end

    // tx stays open while the tdma function is off
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tdma_tx_enable <= 1'b1;
        end else if (!tdma_function_enable) begin
            tdma_tx_enable <= 1'b1;
        end else begin
            tdma_tx_enable <= bch_valid && (bch_ptr == slot_ptr);
        end
    end

    a_slot_in_frame: assert property (
        @(posedge clk) disable iff (!reset_n)
        slot_ptr <= tdma_pkg::SLOT_LAST
    ) else $error("slot pointer left the frame");

endmodule

`default_nettype wire

// ==== logic/gps_time_base.sv ====
`default_nettype none

module gps_time_base (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  timepulse_1,
    input  wire                  timepulse_2,
    input  wire [31:0]           utc_sec,
    output tdma_pkg::gps_time_t  gps_time,
    output logic                 sec_tick,
    output logic                 us_tick
);

    logic [1:0] tp1_sync;
    logic [1:0] tp2_sync;
    logic       tp1_prev;
    logic       tp2_prev;
    logic       tp1_edge;
    logic       tp2_edge;

    ////////////////////////////////////////////////////////////
    // pulse synchronisers and edge detect
    ////////////////////////////////////////////////////////////
    // two flops into the clk domain, third flop for the edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tp1_sync <= '0;
            tp2_sync <= '0;
            tp1_prev <= 1'b0;
            tp2_prev <= 1'b0;
        end else begin
            tp1_sync <= {tp1_sync[0], timepulse_1};
            tp2_sync <= {tp2_sync[0], timepulse_2};
            tp1_prev <= tp1_sync[1];
            tp2_prev <= tp2_sync[1];
        end
    end

    assign tp1_edge = tp1_sync[1] & ~tp1_prev;
    assign tp2_edge = tp2_sync[1] & ~tp2_prev;

    ////////////////////////////////////////////////////////////
    // pulse counters and utc latch
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            gps_time <= '0;
            sec_tick <= 1'b0;
            us_tick  <= 1'b0;
        end else begin
            // strobes line up with the counter update
            sec_tick <= tp1_edge;
            us_tick  <= tp2_edge;
            if (tp1_edge) begin
                // new second, restart the microsecond count
                gps_time.pulse1_count <= gps_time.pulse1_count + 32'd1;
                gps_time.utc_sec      <= utc_sec;
                gps_time.pulse2_count <= '0;
            end else if (tp2_edge) begin
                gps_time.pulse2_count <= gps_time.pulse2_count + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/tdma_pkg.sv ====
`default_nettype none

package tdma_pkg;

    ////////////////////////////////////////////////////////////
    // bus and field widths
    ////////////////////////////////////////////////////////////
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LEN_W  = 14;

    ////////////////////////////////////////////////////////////
    // slot and frame geometry
    ////////////////////////////////////////////////////////////
    // timepulse_2 edges per slot, so one slot is 1 ms
    localparam int SLOT_TICKS  = 1000;
    localparam int FRAME_SLOTS = 3;
    localparam int SLOT_W      = 16;
    localparam int TICK_W      = 10;

    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(SLOT_TICKS - 1);
    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(FRAME_SLOTS - 1);

    ////////////////////////////////////////////////////////////
    // ping packet constants
    ////////////////////////////////////////////////////////////
    // tick count used when the measurement crosses a second
    localparam logic [DATA_W-1:0] MAX_COUNTER2 = 32'hF423F;
    // 30 byte 802.11 header plus 2 bytes of padding
    localparam logic [ADDR_W-1:0] PAYLOAD_OFFSET = 32'h20;
    localparam logic [LEN_W-1:0]  PING_BYTES     = 14'd16;
    localparam logic [DATA_W-1:0] FLAG_PING      = 32'd1;
    localparam logic [DATA_W-1:0] FLAG_ACK_PING  = 32'd2;

    typedef struct packed {
        logic [DATA_W-1:0] utc_sec;
        logic [DATA_W-1:0] pulse1_count;
        logic [DATA_W-1:0] pulse2_count;
    } gps_time_t;

    typedef struct packed {
        logic [DATA_W-1:0] seq;
        logic [DATA_W-1:0] sec;
        logic [DATA_W-1:0] counter2;
    } ping_fields_t;

    // data, low word first: flag, seq, sec, counter2
    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [LEN_W-1:0]    length;
        logic [4*DATA_W-1:0] data;
    } burst_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] seq;
        logic [DATA_W-1:0] delta_t;
    } ping_result_t;

endpackage

`default_nettype wire
